/* files.f */
+incdir+testbench
src/isaPkg.sv
src/uopPkg.sv
src/intAluDecoder.sv
src/memJumpDecoder.sv
src/fpRegRemap.sv
src/uopSelect.sv
src/decoderTop.sv
testbench/decoderTopTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module decoderTopTb -f files.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* src/decoderTop.sv */
`timescale 1ns/1ps
`default_nettype none

module decoderTop import isaPkg::*, uopPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  instrValid,
  input  instrWord              instr,
  input  logic                  reorEn,
  input  logic [REOR_WIDTH-1:0] reorVal,
  output logic                  uopValid,
  output microOp                uop,
  output logic                  decodeError,
  output logic                  reorReject
);

  decodeResult           aluRes;
  decodeResult           memRes;
  logic [REOR_IDX_W-1:0] fpLookup;
  logic [REOR_IDX_W-1:0] fpMapped;

  intAluDecoder intAluDecoder_inst (
    .instr  (instr),
    .result (aluRes)
  );

  memJumpDecoder memJumpDecoder_inst (
    .instr    (instr),
    .fpLookup (fpLookup),
    .fpMapped (fpMapped),
    .result   (memRes)
  );

  fpRegRemap fpRegRemap_inst (
    .clk        (clk),
    .rst        (rst),
    .reorEn     (reorEn),
    .reorVal    (reorVal),
    .fpLookup   (fpLookup),
    .fpMapped   (fpMapped),
    .reorReject (reorReject)
  );

  uopSelect uopSelect_inst (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .aluRes      (aluRes),
    .memRes      (memRes),
    .uopValid    (uopValid),
    .uop         (uop),
    .decodeError (decodeError)
  );

endmodule

`default_nettype wire

/* src/fpRegRemap.sv */
`timescale 1ns/1ps
`default_nettype none

module fpRegRemap import uopPkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  reorEn,
  input  logic [REOR_WIDTH-1:0] reorVal,
  input  logic [REOR_IDX_W-1:0] fpLookup,
  output logic [REOR_IDX_W-1:0] fpMapped,
  output logic                  reorReject
);

  logic [REOR_ENTRIES-1:0][REOR_IDX_W-1:0] remapTab;
  logic [REOR_ENTRIES-1:0][REOR_IDX_W-1:0] reqTab;
  logic                                    reqOk;

  function automatic logic isPerm(input logic [REOR_ENTRIES-1:0][REOR_IDX_W-1:0] v);
    logic [REOR_ENTRIES-1:0] seen;
    seen = '0;
    for (int i = 0; i < REOR_ENTRIES; i++)
      seen[v[i]] = 1'b1;
    return &seen; // every index hit exactly once
  endfunction

  assign reqTab = reorVal;
  assign reqOk = isPerm(reqTab);
  assign reorReject = reorEn && !reqOk;
  assign fpMapped = remapTab[fpLookup];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < REOR_ENTRIES; i++)
        remapTab[i] <= REOR_IDX_W'(i); // identity
    end else if (reorEn && reqOk) begin
      // new entry i takes old entry reqTab[i], all at once
      for (int i = 0; i < REOR_ENTRIES; i++)
        remapTab[i] <= remapTab[reqTab[i]];
    end
  end

  tablePerm: assert property (@(posedge clk) disable iff (rst) isPerm(remapTab))
    else $error("fp reorder table lost its permutation");

endmodule

`default_nettype wire

/* src/intAluDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module intAluDecoder import isaPkg::*, uopPkg::*; (
  input  instrWord    instr,
  output decodeResult result
);

  logic [6:0] opc;
  logic [2:0] f3;
  logic [6:0] f7;
  logic [6:0] f7Chk;
  logic       isImm;
  logic       is32;
  logic       isShift;
  logic       badF7;
  logic       bad32;

  assign opc = instr.r.opcode;
  assign f3 = instr.r.funct3;
  assign f7 = instr.r.funct7;
  assign isImm = (opc == OPC_OPIMM) || (opc == OPC_OPIMM32);
  assign is32 = (opc == OPC_OP32) || (opc == OPC_OPIMM32);
  assign isShift = (f3 == F3_SLL) || (f3 == F3_SRL);

  // immediate shifts keep shamt bit 5 in the funct7 lsb
  assign f7Chk = isImm ? {f7[6:1], 1'b0} : f7;
  assign badF7 = (f7Chk != 7'h00) && (f7Chk != 7'h20) && (!isImm || isShift);

  // 32-bit groups only have add/sub and shifts, shamt limited to 31
  assign bad32 = is32 && (!(f3 == F3_ADD || isShift) || (isImm && isShift && f7[0]));

  always_comb begin
    result = '0;
    result.uop.jumpType = JUMP_NONE;
    result.hit = isImm || (opc == OPC_OP) || (opc == OPC_OP32);
    result.illegal = badF7 || bad32;

    result.uop.rA.idx = instr.r.rs1;
    result.uop.rAUse = 1'b1;
    result.uop.rT.idx = instr.r.rd;
    result.uop.rTUse = 1'b1;
    result.uop.flagsWrite = 1'b1;

    if (isImm) begin
      result.uop.useBConst = 1'b1;
      if (isShift)
        result.uop.constant = 64'(instr.i.imm[5:0]); // shamt, zero-extended
      else
        result.uop.constant = {{52{instr.i.imm[11]}}, instr.i.imm};
    end else begin
      result.uop.rB.idx = instr.r.rs2;
      result.uop.rBUse = 1'b1;
    end

    case (f3)
      F3_ADD: begin
        result.uop.port = PORT_ALU;
        if (!isImm && f7[5])
          result.uop.operation = is32 ? OP_SUB32S : OP_SUB64;
        else
          result.uop.operation = is32 ? OP_ADD32S : OP_ADD64;
      end
      F3_SLL: begin
        result.uop.port = PORT_SHIFT;
        result.uop.operation = is32 ? OP_SHL32 : OP_SHL64;
      end
      F3_SRL: begin
        result.uop.port = PORT_SHIFT;
        if (f7[5])
          result.uop.operation = is32 ? OP_SAR32 : OP_SAR64;
        else
          result.uop.operation = is32 ? OP_SHR32 : OP_SHR64;
      end
      F3_SLT: begin
        result.uop.port = PORT_MUL; // compares run on the mul port
        result.uop.operation = OP_SLT;
        result.uop.flagsWrite = 1'b0;
      end
      F3_SLTU: begin
        result.uop.port = PORT_MUL;
        result.uop.operation = OP_SLTU;
        result.uop.flagsWrite = 1'b0;
      end
      F3_XOR: begin
        result.uop.port = PORT_ALU;
        result.uop.operation = OP_XOR64;
      end
      F3_OR: begin
        result.uop.port = PORT_ALU;
        result.uop.operation = OP_OR64;
      end
      F3_AND: begin
        result.uop.port = PORT_ALU;
        result.uop.operation = OP_AND64;
      end
      default: begin
        result.uop.port = PORT_ALU;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/isaPkg.sv */
`default_nettype none

package isaPkg;

  localparam int INSTR_WIDTH = 32;

  // major opcodes
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_FLOAD   = 7'b0000111;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_FSTORE  = 7'b0100111;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;
  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;

  // funct3 of the integer groups
  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101; // also sra with funct7 bit 5
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeFmt;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeFmt;

  typedef struct packed {
    logic [6:0] immHi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] immLo;
    logic [6:0] opcode;
  } sTypeFmt;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } uTypeFmt;

  // one fetched word, read in whichever layout the decoder needs
  typedef union packed {
    rTypeFmt r;
    iTypeFmt i;
    sTypeFmt s;
    uTypeFmt u;
  } instrWord;

endpackage

`default_nettype wire

/* src/memJumpDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module memJumpDecoder import isaPkg::*, uopPkg::*; (
  input  instrWord              instr,
  output logic [REOR_IDX_W-1:0] fpLookup,
  input  logic [REOR_IDX_W-1:0] fpMapped,
  output decodeResult           result
);

  logic [INSTR_WIDTH-1:0] raw;
  logic [6:0]             opc;
  logic                   isStore;
  logic                   isFp;
  logic                   rdUse;
  logic [4:0]             fpIdx;
  logic [4:0]             memIdx;
  logic [63:0]            immI;
  logic [63:0]            immS;
  logic [63:0]            immU;
  logic [63:0]            immJ;

  assign raw = instr;
  assign opc = instr.u.opcode;
  assign isStore = (opc == OPC_STORE) || (opc == OPC_FSTORE);
  assign isFp = (opc == OPC_FLOAD) || (opc == OPC_FSTORE);
  assign rdUse = instr.i.rd != 5'd0; // x0 is never written

  // store data reg or load target, only f0..f7 go through the table
  assign fpIdx = isStore ? instr.s.rs2 : instr.i.rd;
  assign fpLookup = fpIdx[REOR_IDX_W-1:0];
  assign memIdx = (isFp && fpIdx < 5'd8) ? {2'b00, fpMapped} : fpIdx;

  assign immI = {{52{instr.i.imm[11]}}, instr.i.imm};
  assign immS = {{52{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
  assign immU = {{32{instr.u.imm[19]}}, instr.u.imm, 12'h000};
  assign immJ = {{44{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0}; // J layout scrambled

  always_comb begin
    result = '0;
    result.uop.jumpType = JUMP_NONE;
    result.uop.rT.idx = instr.i.rd;
    result.uop.rTUse = rdUse;

    case (opc)
      OPC_LOAD, OPC_FLOAD: begin
        result.hit = 1'b1;
        result.uop.operation = OP_MEM | 8'(instr.i.funct3);
        result.uop.port = PORT_LOAD;
        result.uop.rB.idx = instr.i.rs1;
        result.uop.rBUse = 1'b1;
        result.uop.rT.isFp = isFp;
        result.uop.rT.idx = memIdx;
        result.uop.rTUse = isFp || rdUse; // f0 is a real register
        result.uop.constant = immI;
      end
      OPC_STORE, OPC_FSTORE: begin
        result.hit = 1'b1;
        result.uop.operation = OP_MEM | 8'(instr.s.funct3);
        result.uop.port = PORT_STORE;
        result.uop.rB.idx = instr.s.rs1;
        result.uop.rBUse = 1'b1;
        result.uop.rC.isFp = isFp;
        result.uop.rC.idx = memIdx;
        result.uop.rCUse = 1'b1;
        result.uop.rT.idx = 5'd0;
        result.uop.rTUse = 1'b0;
        result.uop.constant = immS;
      end
      OPC_LUI, OPC_AUIPC: begin
        result.hit = 1'b1;
        result.uop.operation = OP_ADD64;
        result.uop.port = PORT_ALU;
        result.uop.useBConst = 1'b1;
        result.uop.constant = immU;
        result.uop.isIPRel = opc == OPC_AUIPC;
      end
      OPC_JAL, OPC_JALR: begin
        result.hit = 1'b1;
        result.uop.operation = OP_ADD64;
        result.uop.port = PORT_ALU;
        result.uop.useBConst = 1'b1;
        result.uop.isIPRel = 1'b1; // IP feeds the A side
        result.uop.isJump = 1'b1;
        result.uop.jumpType = JUMP_LINK;
        if (opc == OPC_JALR) begin
          result.uop.rB.idx = instr.i.rs1;
          result.uop.rBUse = 1'b1;
          result.uop.constant = immI;
        end else begin
          result.uop.constant = immJ;
        end
      end
      default: begin
        result.hit = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* src/uopPkg.sv */
`default_nettype none

package uopPkg;

  typedef struct packed {
    logic       isFp; // FP register file
    logic [4:0] idx;
  } regRef;

  localparam regRef REG_LINK = '{isFp: 1'b0, idx: 5'd1};

  // execution ports
  localparam logic [3:0] PORT_LOAD  = 4'd1;
  localparam logic [3:0] PORT_STORE = 4'd2;
  localparam logic [3:0] PORT_SHIFT = 4'd3;
  localparam logic [3:0] PORT_ALU   = 4'd4;
  localparam logic [3:0] PORT_MUL   = 4'd5;

  localparam logic [7:0] OP_ADD64  = 8'h01;
  localparam logic [7:0] OP_ADD32S = 8'h02;
  localparam logic [7:0] OP_SUB64  = 8'h03;
  localparam logic [7:0] OP_SUB32S = 8'h04;
  localparam logic [7:0] OP_XOR64  = 8'h05;
  localparam logic [7:0] OP_OR64   = 8'h06;
  localparam logic [7:0] OP_AND64  = 8'h07;
  localparam logic [7:0] OP_SLT    = 8'h08;
  localparam logic [7:0] OP_SLTU   = 8'h09;
  localparam logic [7:0] OP_SHL64  = 8'h10;
  localparam logic [7:0] OP_SHR64  = 8'h11;
  localparam logic [7:0] OP_SAR64  = 8'h12;
  localparam logic [7:0] OP_SHL32  = 8'h13;
  localparam logic [7:0] OP_SHR32  = 8'h14;
  localparam logic [7:0] OP_SAR32  = 8'h15;
  localparam logic [7:0] OP_MEM    = 8'h20; // low 3 bits carry funct3 (access size)

  localparam logic [4:0] JUMP_NONE = 5'd16;
  localparam logic [4:0] JUMP_LINK = 5'd17;

  // FP reorder table
  localparam int REOR_ENTRIES = 8;
  localparam int REOR_IDX_W   = 3;
  localparam int REOR_WIDTH   = 24;

  typedef struct packed {
    logic [7:0]  operation;
    logic [3:0]  port;
    regRef       rA;
    logic        rAUse;
    regRef       rB;
    logic        rBUse;
    regRef       rT;
    logic        rTUse;
    regRef       rC; // store data
    logic        rCUse;
    logic        useBConst;
    logic [63:0] constant;
    logic        isIPRel;
    logic        isJump;
    logic [4:0]  jumpType;
    logic        flagsWrite;
  } microOp;

  typedef struct packed {
    logic   hit;
    logic   illegal;
    microOp uop;
  } decodeResult;

endpackage

`default_nettype wire

/* src/uopSelect.sv */
`timescale 1ns/1ps
`default_nettype none

module uopSelect import uopPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        instrValid,
  input  decodeResult aluRes,
  input  decodeResult memRes,
  output logic        uopValid,
  output microOp      uop,
  output logic        decodeError
);

  microOp nextUop;
  logic   nextErr;

  always_comb begin
    if (aluRes.hit) begin
      nextUop = aluRes.uop;
      nextErr = aluRes.illegal;
    end else if (memRes.hit) begin
      nextUop = memRes.uop;
      nextErr = memRes.illegal;
    end else begin
      // unknown opcode
      nextUop = '0;
      nextUop.jumpType = JUMP_NONE;
      nextErr = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst)
      uopValid <= 1'b0;
    else
      uopValid <= instrValid;
  end

  always_ff @(posedge clk) begin
    if (instrValid) begin
      uop <= nextUop;
      decodeError <= nextErr;
    end
  end

  // decoders own disjoint opcode sets
  oneHit: assert property (@(posedge clk) disable iff (rst)
    instrValid |-> !(aluRes.hit && memRes.hit))
    else $error("both decoders claimed the same instruction");

endmodule

`default_nettype wire

/* testbench/uopModel.svh */
`ifndef UOP_MODEL_SVH
`define UOP_MODEL_SVH

// expected results straight from the decode rules, on the raw 32-bit word

function automatic logic [63:0] sext12(input logic [11:0] v);
  return {{52{v[11]}}, v};
endfunction

function automatic logic isPermutation(input logic [REOR_WIDTH-1:0] v);
  logic found;
  logic ok;
  ok = 1'b1;
  for (int k = 0; k < REOR_ENTRIES; k++) begin
    found = 1'b0;
    for (int i = 0; i < REOR_ENTRIES; i++)
      if (v[3*i +: 3] == 3'(k))
        found = 1'b1;
    if (!found)
      ok = 1'b0; // value k missing
  end
  return ok;
endfunction

function automatic void resetTable();
  for (int i = 0; i < REOR_ENTRIES; i++)
    modelTab[i] = 3'(i);
endfunction

function automatic void applyReorder(input logic [REOR_WIDTH-1:0] val);
  logic [2:0] old [REOR_ENTRIES];
  for (int i = 0; i < REOR_ENTRIES; i++)
    old[i] = modelTab[i];
  for (int i = 0; i < REOR_ENTRIES; i++)
    modelTab[i] = old[val[3*i +: 3]];
endfunction

function automatic microOp expectAlu(input logic [31:0] w, output logic err);
  microOp m;
  logic imm;
  logic w32;
  logic shift;
  logic bad7;
  logic [2:0] f3;
  imm = (w[6:0] == OPC_OPIMM) || (w[6:0] == OPC_OPIMM32);
  w32 = (w[6:0] == OPC_OP32) || (w[6:0] == OPC_OPIMM32);
  f3 = w[14:12];
  shift = (f3 == F3_SLL) || (f3 == F3_SRL);
  m = '0;
  m.jumpType = JUMP_NONE;
  m.rA.idx = w[19:15];
  m.rAUse = 1'b1;
  m.rT.idx = w[11:7];
  m.rTUse = 1'b1;
  m.flagsWrite = 1'b1;
  if (imm) begin
    m.useBConst = 1'b1;
    m.constant = shift ? {58'h0, w[25:20]} : sext12(w[31:20]);
  end else begin
    m.rB.idx = w[24:20];
    m.rBUse = 1'b1;
  end
  // imm shifts hold shamt bit 5 at bit 25
  bad7 = imm ? (w[31:26] != 6'h00 && w[31:26] != 6'h10) : (w[31:25] != 7'h00 && w[31:25] != 7'h20);
  err = bad7 && (!imm || shift);
  err = err || (w32 && !(f3 == F3_ADD || shift)) || (w32 && imm && shift && w[25]);
  case (f3)
    F3_ADD: begin
      m.port = PORT_ALU;
      if (!imm && w[30])
        m.operation = w32 ? OP_SUB32S : OP_SUB64;
      else
        m.operation = w32 ? OP_ADD32S : OP_ADD64;
    end
    F3_SLL: begin
      m.port = PORT_SHIFT;
      m.operation = w32 ? OP_SHL32 : OP_SHL64;
    end
    F3_SRL: begin
      m.port = PORT_SHIFT;
      if (w[30])
        m.operation = w32 ? OP_SAR32 : OP_SAR64;
      else
        m.operation = w32 ? OP_SHR32 : OP_SHR64;
    end
    F3_SLT, F3_SLTU: begin
      m.port = PORT_MUL;
      m.operation = (f3 == F3_SLT) ? OP_SLT : OP_SLTU;
      m.flagsWrite = 1'b0;
    end
    F3_XOR: begin
      m.port = PORT_ALU;
      m.operation = OP_XOR64;
    end
    F3_OR: begin
      m.port = PORT_ALU;
      m.operation = OP_OR64;
    end
    default: begin
      m.port = PORT_ALU;
      m.operation = OP_AND64;
    end
  endcase
  return m;
endfunction

function automatic microOp expectMem(input logic [31:0] w);
  microOp m;
  logic store;
  logic fp;
  logic [4:0] data;
  store = (w[6:0] == OPC_STORE) || (w[6:0] == OPC_FSTORE);
  fp = (w[6:0] == OPC_FLOAD) || (w[6:0] == OPC_FSTORE);
  data = store ? w[24:20] : w[11:7];
  if (fp && data < 5'd8)
    data = {2'b00, modelTab[data[2:0]]};
  m = '0;
  m.jumpType = JUMP_NONE;
  m.operation = {OP_MEM[7:3], w[14:12]}; // size in the low bits
  m.rB.idx = w[19:15];
  m.rBUse = 1'b1;
  if (store) begin
    m.port = PORT_STORE;
    m.rC.isFp = fp;
    m.rC.idx = data;
    m.rCUse = 1'b1;
    m.constant = sext12({w[31:25], w[11:7]});
  end else begin
    m.port = PORT_LOAD;
    m.rT.isFp = fp;
    m.rT.idx = data;
    m.rTUse = fp || (w[11:7] != 5'd0); // f0 is a real FP register
    m.constant = sext12(w[31:20]);
  end
  return m;
endfunction

function automatic microOp expectUpperJump(input logic [31:0] w);
  microOp m;
  m = '0;
  m.jumpType = JUMP_NONE;
  m.operation = OP_ADD64;
  m.port = PORT_ALU;
  m.useBConst = 1'b1;
  m.rT.idx = w[11:7];
  m.rTUse = w[11:7] != 5'd0;
  m.constant = {{32{w[31]}}, w[31:12], 12'h000};
  m.isIPRel = (w[6:0] != OPC_LUI);
  if (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) begin
    m.isJump = 1'b1;
    m.jumpType = JUMP_LINK;
    if (w[6:0] == OPC_JALR) begin
      m.rB.idx = w[19:15];
      m.rBUse = 1'b1;
      m.constant = sext12(w[31:20]);
    end else begin
      m.constant = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    end
  end
  return m;
endfunction

function automatic microOp expectUop(input logic [31:0] w, output logic err);
  microOp m;
  m = '0;
  m.jumpType = JUMP_NONE;
  err = 1'b0;
  case (w[6:0])
    OPC_OP, OPC_OP32, OPC_OPIMM, OPC_OPIMM32: m = expectAlu(w, err);
    OPC_LOAD, OPC_FLOAD, OPC_STORE, OPC_FSTORE: m = expectMem(w);
    OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: m = expectUpperJump(w);
    default: err = 1'b1;
  endcase
  return m;
endfunction

`endif

/* testbench/decoderTopTb.sv */
`timescale 1ns/1ps
`default_nettype none

module decoderTopTb import isaPkg::*, uopPkg::*; ();

  localparam int SEED = 80994;
  localparam int RESET_CYCLES = 16;
  localparam int TEST_CYCLES = 2000;
  localparam int NUM_TESTS = 6;
  localparam int CYCLE_LIMIT = NUM_TESTS * TEST_CYCLES * 3 / 2 + 2000; // half again as margin

  typedef struct packed {
    logic   valid;
    logic   err;
    microOp uop;
  } expEntry;

  logic                  clk;
  logic                  rst;
  logic                  instrValid;
  instrWord              instr;
  logic                  reorEn;
  logic [REOR_WIDTH-1:0] reorVal;
  logic                  uopValid;
  microOp                uop;
  logic                  decodeError;
  logic                  reorReject;

  expEntry    expQ [$];
  logic [2:0] modelTab [REOR_ENTRIES];
  int         checks = 0;
  int         errors = 0;
  int         cycles = 0;

  `include "uopModel.svh"

  decoderTop decoderTop_inst (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .instr       (instr),
    .reorEn      (reorEn),
    .reorVal     (reorVal),
    .uopValid    (uopValid),
    .uop         (uop),
    .decodeError (decodeError),
    .reorReject  (reorReject)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  task automatic checkValue(input string name, input logic [127:0] got, input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("Fail %s: got 0x%0h expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic checkOutputs();
    expEntry e;
    if (expQ.size() == 0)
      return;
    e = expQ.pop_front();
    checkValue("uopValid", 128'(uopValid), 128'(e.valid));
    if (e.valid && uopValid) begin
      checkValue("decodeError", 128'(decodeError), 128'(e.err));
      checkValue("uop.operation", 128'(uop.operation), 128'(e.uop.operation));
      checkValue("uop.port", 128'(uop.port), 128'(e.uop.port));
      checkValue("uop.constant", 128'(uop.constant), 128'(e.uop.constant));
      checkValue("uop", 128'(uop), 128'(e.uop)); // registers, use bits and flags
    end
  endtask

  // checks the last result and drives the next inputs
  task automatic issue(input logic r, input logic v, input logic [31:0] w,
                       input logic en, input logic [REOR_WIDTH-1:0] val);
    expEntry e;
    logic    err;
    logic    perm;
    @(posedge clk);
    #1;
    checkOutputs();
    rst = r;
    instrValid = v;
    instr = w;
    reorEn = en;
    reorVal = val;
    e.valid = v && !r;
    e.uop = expectUop(w, err); // update lands after this edge
    e.err = err;
    perm = isPermutation(val);
    #1;
    checkValue("reorReject", 128'(reorReject), 128'(en && !perm));
    if (r)
      resetTable();
    else if (en && perm)
      applyReorder(val);
    expQ.push_back(e);
  endtask

  function automatic logic [REOR_WIDTH-1:0] randomPerm();
    logic [2:0]            p [REOR_ENTRIES];
    logic [2:0]            t;
    logic [REOR_WIDTH-1:0] word;
    int                    j;
    for (int i = 0; i < REOR_ENTRIES; i++)
      p[i] = 3'(i);
    for (int i = REOR_ENTRIES - 1; i > 0; i--) begin
      j = $urandom_range(i);
      t = p[i];
      p[i] = p[3'(j)];
      p[3'(j)] = t;
    end
    for (int i = 0; i < REOR_ENTRIES; i++)
      word[3*i +: 3] = p[i];
    return word;
  endfunction

  function automatic logic [6:0] pickFunct7();
    case ($urandom_range(7))
      0: return 7'($urandom); // usually illegal
      1, 2, 3: return 7'h20;
      default: return 7'h00;
    endcase
  endfunction

  function automatic logic isListed(input logic [6:0] opc);
    case (opc)
      OPC_LOAD, OPC_FLOAD, OPC_STORE, OPC_FSTORE, OPC_OPIMM, OPC_OPIMM32,
      OPC_OP, OPC_OP32, OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] randomInstr(input int kind);
    logic [31:0] w;
    logic [6:0]  f7;
    logic [6:0]  opcs [4];
    logic [2:0]  f3s [6];
    w = $urandom;
    f7 = pickFunct7();
    f3s = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
    case (kind)
      1, 2: opcs = '{OPC_OP, OPC_OP32, OPC_OPIMM, OPC_OPIMM32};
      3: opcs = '{OPC_LOAD, OPC_FLOAD, OPC_STORE, OPC_FSTORE};
      4: opcs = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR};
      default: opcs = '{OPC_FLOAD, OPC_FSTORE, OPC_FLOAD, OPC_FSTORE};
    endcase
    w[6:0] = opcs[2'($urandom_range(3))];
    case (kind)
      1: begin
        w[14:12] = f3s[3'($urandom_range(5))];
        if (w[3] && $urandom_range(3) != 0)
          w[14:12] = F3_ADD; // 32-bit groups mostly add/sub
        if (w[5])
          w[31:25] = f7;
      end
      2: begin
        w[14:12] = $urandom_range(1) ? F3_SLL : F3_SRL;
        if (w[5])
          w[31:25] = f7;
        else
          w[31:26] = f7[6:1]; // bit 25 stays random shamt
      end
      4: begin
        if ($urandom_range(3) == 0)
          w[11:7] = 5'd0;
      end
      5: begin
        if ($urandom_range(3) != 0) begin
          w[11:10] = 2'b00; // f0..f7 most of the time
          w[24:23] = 2'b00;
        end
      end
      6: begin
        w[6:0] = 7'($urandom);
        while (isListed(w[6:0]))
          w[6:0] = 7'($urandom);
      end
      default: ;
    endcase
    return w;
  endfunction

  task automatic runTest(input int id, input string name);
    int                    errStart;
    logic                  v;
    logic                  en;
    logic [REOR_WIDTH-1:0] val;
    errStart = errors;
    if (id == 6) begin
      for (int n = 0; n < RESET_CYCLES; n++)
        issue(1'b1, 1'($urandom_range(1)), $urandom, 1'b0, '0);
    end
    for (int n = 0; n < TEST_CYCLES; n++) begin
      v = (id == 6) ? 1'($urandom_range(1)) : 1'b1; // gaps only in the last test
      en = (id == 5) && ($urandom_range(5) == 0);
      val = $urandom_range(1) ? randomPerm() : REOR_WIDTH'($urandom);
      issue(1'b0, v, randomInstr(id), en, val);
    end
    $display("test %0d (%s) done: %0d errors", id, name, errors - errStart);
  endtask

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    instrValid = 1'b0;
    instr = '0;
    reorEn = 1'b0;
    reorVal = '0;
    resetTable();
    for (int n = 0; n < RESET_CYCLES; n++)
      issue(1'b1, 1'($urandom_range(1)), $urandom, 1'b0, '0);
    runTest(1, "alu register and immediate");
    runTest(2, "shifts");
    runTest(3, "loads and stores");
    runTest(4, "lui auipc jal jalr");
    runTest(5, "fp reorder table");
    runTest(6, "unknown opcodes and valid timing");
    issue(1'b0, 1'b0, '0, 1'b0, '0); // collects the last result
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
